// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the debug UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_debug_uart_top \
    -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== source/button_trigger.sv ====
// Push button trigger

`timescale 1ns/1ps

module button_trigger (
    input  logic clk,
    input  logic resetb,
    input  logic btn_i,
    output logic trigger_o
);

    // three stage synchroniser, stage 2 is the clean copy
    logic [2:0] btn_sync;
    // last synchronised value for edge detect
    logic       btn_prev;

    // ------------------------------------------------
    // sync chain and edge pulse
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetb) begin
            btn_sync  <= 3'b000;
            btn_prev  <= 1'b0;
            trigger_o <= 1'b0;
        end else begin
            // shift new sample in at the bottom
            btn_sync  <= {btn_sync[1:0], btn_i};
            btn_prev  <= btn_sync[2];
            // rising edge only, held button gives a single pulse
            trigger_o <= btn_sync[2] & ~btn_prev;
        end
    end

endmodule

// ==== source/debug_msg_pkg.sv ====
// Debug message definitions

package debug_msg_pkg;

    // ------------------------------------------------
    // message geometry
    // ------------------------------------------------
    // "DBG: " + 16 counting bytes + CR LF
    localparam int MSG_LEN   = 23;
    // index wide enough to hold MSG_LEN itself
    localparam int MSG_IDX_W = 5;

    // one byte on the debug path
    typedef logic [7:0] dbg_byte_t;

    // ------------------------------------------------
    // state encodings
    // ------------------------------------------------
    // sequencer, waiting or sending
    typedef enum logic {
        MSG_IDLE,
        MSG_SEND
    } msg_state_t;

    // serial frame phases
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    // ------------------------------------------------
    // message table, entry 0 sent first
    // ------------------------------------------------
    localparam dbg_byte_t [0:MSG_LEN-1] DBG_MSG = {
        8'h44, 8'h42, 8'h47, 8'h3A, 8'h20,
        8'h00, 8'h01, 8'h02, 8'h03,
        8'h04, 8'h05, 8'h06, 8'h07,
        8'h08, 8'h09, 8'h0A, 8'h0B,
        8'h0C, 8'h0D, 8'h0E, 8'h0F,
        // carriage return, line feed
        8'h0D, 8'h0A
    };

endpackage

// ==== source/debug_msg_sequencer.sv ====
// Debug message sequencer

`timescale 1ns/1ps

module debug_msg_sequencer
    import debug_msg_pkg::*;
#(
    parameter int SLOT_CYCLES = 64
) (
    input  logic      clk,
    input  logic      resetb,
    input  logic      trigger_i,
    output dbg_byte_t byte_o,
    output logic      send_o,
    output logic      active_o
);

    // slot counter width, at least one bit
    localparam int SLOT_W = (SLOT_CYCLES > 1) ? $clog2(SLOT_CYCLES) : 1;

    msg_state_t             msg_state;
    logic [SLOT_W-1:0]      slot_cnt;
    logic [MSG_IDX_W-1:0]   byte_idx;
    logic                   slot_end;
    logic                   msg_done;

    // ------------------------------------------------
    // slot bookkeeping
    // ------------------------------------------------
    // last cycle of the current slot
    assign slot_end = (slot_cnt == SLOT_W'(SLOT_CYCLES - 1));
    // all bytes out, this slot only closes the message
    assign msg_done = (byte_idx == MSG_IDX_W'(MSG_LEN));

    // ------------------------------------------------
    // control FSM
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetb) begin
            msg_state <= MSG_IDLE;
            slot_cnt  <= '0;
            byte_idx  <= '0;
            send_o    <= 1'b0;
            active_o  <= 1'b0;
        end else begin
            // strobe lasts one cycle
            send_o <= 1'b0;
            case (msg_state)
                MSG_IDLE: begin
                    if (trigger_i) begin
                        msg_state <= MSG_SEND;
                        active_o  <= 1'b1;
                        // one clock already gone at the trigger edge
                        slot_cnt  <= SLOT_W'(1);
                        byte_idx  <= '0;
                    end
                end
                MSG_SEND: begin
                    // triggers are not looked at here
                    if (slot_end) begin
                        slot_cnt <= '0;
                        if (msg_done) begin
                            msg_state <= MSG_IDLE;
                            active_o  <= 1'b0;
                        end else begin
                            send_o   <= 1'b1;
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end else begin
                        slot_cnt <= slot_cnt + 1'b1;
                    end
                end
                default: begin
                    msg_state <= MSG_IDLE;
                    active_o  <= 1'b0;
                end
            endcase
        end
    end

    // byte register, only loaded alongside a strobe
    always_ff @(posedge clk) begin
        if (msg_state == MSG_SEND && slot_end && !msg_done) begin
            byte_o <= DBG_MSG[byte_idx];
        end
    end

endmodule

// ==== source/debug_uart_top.sv ====
// Debug UART top level

`timescale 1ns/1ps

module debug_uart_top
    import debug_msg_pkg::*;
#(
    // clocks per serial bit
    parameter int BAUD_DIV    = 4,
    // clocks per byte slot, keep above 10 * BAUD_DIV
    parameter int SLOT_CYCLES = 64
) (
    input  logic      clk,
    input  logic      resetb,
    input  logic      btn_s2_i,
    output logic      uart_tx_o,
    output dbg_byte_t dbg_byte_o,
    output logic      dbg_send_o,
    output logic      dbg_active_o
);

    // one cycle pulse per button press
    logic btn_trigger;

    // ------------------------------------------------
    // decode, button to trigger
    // ------------------------------------------------
    button_trigger i_button_trigger (
        .clk       (clk),
        .resetb    (resetb),
        .btn_i     (btn_s2_i),
        .trigger_o (btn_trigger)
    );

    // ------------------------------------------------
    // execute, message bytes on a slot grid
    // ------------------------------------------------
    debug_msg_sequencer #(
        .SLOT_CYCLES (SLOT_CYCLES)
    ) i_debug_msg_sequencer (
        .clk       (clk),
        .resetb    (resetb),
        .trigger_i (btn_trigger),
        .byte_o    (dbg_byte_o),
        .send_o    (dbg_send_o),
        .active_o  (dbg_active_o)
    );

    // ------------------------------------------------
    // result, bytes onto the serial line
    // ------------------------------------------------
    // frame always ends inside one slot, so busy is not needed here
    uart_tx_serializer #(
        .BAUD_DIV (BAUD_DIV)
    ) i_uart_tx_serializer (
        .clk       (clk),
        .resetb    (resetb),
        .byte_i    (dbg_byte_o),
        .send_i    (dbg_send_o),
        .uart_tx_o (uart_tx_o),
        .busy_o    ()
    );

endmodule

// ==== source/uart_tx_serializer.sv ====
// UART 8N1 transmitter

`timescale 1ns/1ps

module uart_tx_serializer
    import debug_msg_pkg::*;
#(
    parameter int BAUD_DIV = 4
) (
    input  logic      clk,
    input  logic      resetb,
    input  dbg_byte_t byte_i,
    input  logic      send_i,
    output logic      uart_tx_o,
    output logic      busy_o
);

    // baud counter width, at least one bit
    localparam int BAUD_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

    tx_state_t         tx_state;
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_cnt;
    dbg_byte_t         shift_q;
    logic              bit_end;

    // last clock of the current bit period
    assign bit_end = (baud_cnt == BAUD_W'(BAUD_DIV - 1));
    // busy for start, data and stop bits
    assign busy_o  = (tx_state != TX_IDLE);

    // ------------------------------------------------
    // frame FSM
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetb) begin
            tx_state  <= TX_IDLE;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            uart_tx_o <= 1'b1;
        end else begin
            // free running within a frame, wraps each bit
            if (tx_state == TX_IDLE || bit_end) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
            case (tx_state)
                TX_IDLE: begin
                    if (send_i) begin
                        // start bit from the next cycle on
                        tx_state  <= TX_START;
                        uart_tx_o <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        tx_state  <= TX_DATA;
                        bit_cnt   <= '0;
                        uart_tx_o <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            tx_state  <= TX_STOP;
                            uart_tx_o <= 1'b1;
                        end else begin
                            bit_cnt   <= bit_cnt + 1'b1;
                            uart_tx_o <= shift_q[1];
                        end
                    end
                end
                TX_STOP: begin
                    // line stays high into idle
                    if (bit_end) begin
                        tx_state <= TX_IDLE;
                    end
                end
                default: begin
                    tx_state  <= TX_IDLE;
                    uart_tx_o <= 1'b1;
                end
            endcase
        end
    end

    // shift register, lsb first
    always_ff @(posedge clk) begin
        if (tx_state == TX_IDLE && send_i) begin
            shift_q <= byte_i;
        end else if (tx_state == TX_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// ==== src.f ====
source/debug_msg_pkg.sv
source/button_trigger.sv
source/debug_msg_sequencer.sv
source/uart_tx_serializer.sv
source/debug_uart_top.sv
test/debug_uart_assert.sv
test/tb_debug_uart_top.sv

// ==== test/debug_uart_assert.sv ====
// Debug UART assertions

`timescale 1ns/1ps

module debug_uart_assert
    import debug_msg_pkg::*;
#(
    parameter int BAUD_DIV    = 4,
    parameter int SLOT_CYCLES = 64
) (
    input logic      clk,
    input logic      resetb,
    input logic      btn_i,
    input logic      uart_tx_i,
    input dbg_byte_t byte_i,
    input logic      send_i,
    input logic      active_i
);

    localparam int FRAME_CYCLES = 10 * BAUD_DIV;

    // failures seen so far, read by the testbench
    int        fail_cnt = 0;
    logic      resetb_q;
    logic      active_q;
    logic      btn_q;
    // strobes so far in this message
    int        strobe_idx;
    // clocks since last strobe or message start
    int        slot_age;
    // position inside the serial frame, 0 when idle
    int        frame_t;
    dbg_byte_t frame_byte;
    // clocks since an idle press
    int        press_age;
    int        bit_idx;
    int        bit_phase;
    dbg_byte_t shifted;
    logic      exp_bit;

    // --------------------------------------------------
    // reference state from the timing rules
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        resetb_q <= resetb;
        if (!resetb) begin
            active_q   <= 1'b0;
            btn_q      <= 1'b0;
            strobe_idx <= 0;
            slot_age   <= 0;
            frame_t    <= 0;
            press_age  <= 0;
        end else begin
            active_q <= active_i;
            btn_q    <= btn_i;
            if (!active_i) begin
                strobe_idx <= 0;
            end else if (send_i) begin
                strobe_idx <= strobe_idx + 1;
            end
            if (send_i) begin
                slot_age <= 1;
            end else if (active_i) begin
                slot_age <= slot_age + 1;
            end else begin
                slot_age <= 0;
            end
            // frame starts one clock after the strobe
            if (send_i) begin
                frame_t    <= 1;
                frame_byte <= byte_i;
            end else if (frame_t != 0 && frame_t < FRAME_CYCLES) begin
                frame_t <= frame_t + 1;
            end else begin
                frame_t <= 0;
            end
            // sync 3, trigger 1, active 1
            if (press_age == 5) begin
                press_age <= 0;
            end else if (press_age != 0) begin
                press_age <= press_age + 1;
            end else if (btn_i && !btn_q && !active_i) begin
                press_age <= 1;
            end
        end
    end

    // expected line level, start low, data lsb first, stop high
    always_comb begin
        bit_idx   = (frame_t - 1) / BAUD_DIV;
        bit_phase = (frame_t - 1) % BAUD_DIV;
        shifted   = frame_byte >> (bit_idx - 1);
        if (bit_idx == 0) begin
            exp_bit = 1'b0;
        end else if (bit_idx <= 8) begin
            exp_bit = shifted[0];
        end else begin
            exp_bit = 1'b1;
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    // in reset and first cycle out of it
    assert property (@(posedge clk)
        (!resetb || !resetb_q) |=> uart_tx_i && !send_i && !active_i)
        else begin
            $error("reset: outputs not at idle values during or just after reset");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!resetb) send_i |-> active_i)
        else begin
            $error("slot_timing: byte strobe seen while message not active");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!resetb) send_i |-> strobe_idx < MSG_LEN)
        else begin
            $error("message_content: more strobes than the message holds");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!resetb)
        send_i && strobe_idx < MSG_LEN |-> byte_i == DBG_MSG[strobe_idx[MSG_IDX_W-1:0]])
        else begin
            $error("ERROR message_content: byte %0d expected %h actual %h",
                strobe_idx, DBG_MSG[strobe_idx[MSG_IDX_W-1:0]], byte_i);
            fail_cnt++;
        end

    // first strobe one clock closer, active rises a clock after trigger
    assert property (@(posedge clk) disable iff (!resetb)
        send_i |-> slot_age == ((strobe_idx == 0) ? SLOT_CYCLES - 1 : SLOT_CYCLES))
        else begin
            $error("ERROR slot_timing: expected %0d actual %0d",
                (strobe_idx == 0) ? SLOT_CYCLES - 1 : SLOT_CYCLES, slot_age);
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!resetb)
        !active_i && active_q |-> strobe_idx == MSG_LEN && slot_age == SLOT_CYCLES)
        else begin
            $error("ERROR message_end: strobes expected %0d actual %0d, tail %0d actual %0d",
                MSG_LEN, strobe_idx, SLOT_CYCLES, slot_age);
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!resetb)
        frame_t != 0 && bit_phase == BAUD_DIV / 2 |-> uart_tx_i == exp_bit)
        else begin
            $error("ERROR serial_frame: bit %0d of %h expected %b actual %b",
                bit_idx, frame_byte, exp_bit, uart_tx_i);
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!resetb) frame_t == 0 |-> uart_tx_i)
        else begin
            $error("serial_frame: line low outside a frame");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!resetb)
        press_age == 5 |-> active_i && !active_q)
        else begin
            $error("press: idle press did not start a message on time");
            fail_cnt++;
        end

endmodule

bind debug_uart_top debug_uart_assert #(
    .BAUD_DIV    (BAUD_DIV),
    .SLOT_CYCLES (SLOT_CYCLES)
) i_assert (
    .clk       (clk),
    .resetb    (resetb),
    .btn_i     (btn_s2_i),
    .uart_tx_i (uart_tx_o),
    .byte_i    (dbg_byte_o),
    .send_i    (dbg_send_o),
    .active_i  (dbg_active_o)
);

// ==== test/tb_debug_uart_top.sv ====
// Debug UART testbench

`timescale 1ns/1ps

module tb_debug_uart_top;
    import debug_msg_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int SLOT_CYCLES = 64;
    // whole message plus a little slack
    localparam int MSG_CYCLES  = (MSG_LEN + 1) * SLOT_CYCLES + 16;
    // three messages of 24 slots, plus margin
    localparam int WATCHDOG_NS = (3 * 24 + 8) * SLOT_CYCLES * CLK_PERIOD;

    logic      clk = 1'b0;
    logic      resetb;
    logic      btn_s2;
    logic      uart_tx;
    dbg_byte_t dbg_byte;
    logic      dbg_send;
    logic      dbg_active;
    int        seed;
    int        tb_fails = 0;
    int        passed = 0;
    int        failed = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    debug_uart_top i_dut (
        .clk          (clk),
        .resetb       (resetb),
        .btn_s2_i     (btn_s2),
        .uart_tx_o    (uart_tx),
        .dbg_byte_o   (dbg_byte),
        .dbg_send_o   (dbg_send),
        .dbg_active_o (dbg_active)
    );

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic int error_total();
        return i_dut.i_assert.fail_cnt + tb_fails;
    endfunction

    // advance n clocks, land just after the edge
    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // random hold, one trigger whatever the length
    task automatic press_button();
        int hold;
        hold   = 4 + ($unsigned($random(seed)) % 12);
        btn_s2 = 1'b1;
        step(hold);
        btn_s2 = 1'b0;
    endtask

    task automatic wait_active(input logic level, input int limit, input string name);
        int n;
        n = 0;
        while (dbg_active !== level && n < limit) begin
            step(1);
            n++;
        end
        if (dbg_active !== level) begin
            $display("%s: dbg_active_o did not go to %0b within %0d clocks", name, level, limit);
            tb_fails++;
        end
    endtask

    task automatic end_test(input string name, input int mark);
        int fails;
        fails = error_total() - mark;
        if (fails == 0) begin
            $display("test %s: passed", name);
            passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, fails);
            failed++;
        end
    endtask

    // --------------------------------------------------
    // watchdog
    // --------------------------------------------------
    initial begin
        #WATCHDOG_NS;
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        int mark;
        seed   = 2;
        resetb = 1'b0;
        btn_s2 = 1'b0;
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        resetb = 1'b1;
        step(4);
        end_test("reset", 0);

        // one press, full message and frames
        mark = error_total();
        press_button();
        wait_active(1'b1, 20, "single_message");
        wait_active(1'b0, MSG_CYCLES, "single_message");
        step(8);
        end_test("single_message", mark);

        // second press lands mid message
        mark = error_total();
        press_button();
        wait_active(1'b1, 20, "ignored_press");
        step(5 * SLOT_CYCLES);
        press_button();
        wait_active(1'b0, MSG_CYCLES, "ignored_press");
        step(8);
        end_test("ignored_press", mark);

        // fresh message after the end
        mark = error_total();
        press_button();
        wait_active(1'b1, 20, "new_message");
        wait_active(1'b0, MSG_CYCLES, "new_message");
        step(8);
        end_test("new_message", mark);

        $display("tests: %0d run, %0d passed, %0d failed", passed + failed, passed, failed);
        if (error_total() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
